//--- source/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

    localparam int WORD_W    = 16;
    localparam int ADDR_W    = 9;
    localparam int REG_N_W   = 3;
    localparam int REG_COUNT = 8;

    typedef logic [WORD_W-1:0]  word_t;
    typedef logic [ADDR_W-1:0]  addr_t;
    typedef logic [REG_N_W-1:0] reg_num_t;
    typedef logic [1:0]         shift_t;
    typedef logic [1:0]         alu_op_t;
    typedef logic [1:0]         mem_cmd_t;

    // opcodes, instr[15:13]
    localparam logic [2:0] OPC_BRANCH = 3'b001;
    localparam logic [2:0] OPC_LDR    = 3'b011;
    localparam logic [2:0] OPC_STR    = 3'b100;
    localparam logic [2:0] OPC_ALU    = 3'b101;
    localparam logic [2:0] OPC_MOV    = 3'b110;
    localparam logic [2:0] OPC_HALT   = 3'b111;

    localparam logic [1:0] OP_MOV_IMM = 2'b10;
    localparam logic [1:0] OP_MOV_REG = 2'b00;

    localparam alu_op_t ALU_ADD = 2'b00;
    localparam alu_op_t ALU_CMP = 2'b01;
    localparam alu_op_t ALU_AND = 2'b10;
    localparam alu_op_t ALU_MVN = 2'b11;

    // branch conditions, instr[10:8]
    localparam logic [2:0] COND_AL = 3'b000;
    localparam logic [2:0] COND_EQ = 3'b001;
    localparam logic [2:0] COND_NE = 3'b010;
    localparam logic [2:0] COND_LT = 3'b011;
    localparam logic [2:0] COND_LE = 3'b100;

    localparam mem_cmd_t MEM_NONE  = 2'b00;
    localparam mem_cmd_t MEM_READ  = 2'b01;
    localparam mem_cmd_t MEM_WRITE = 2'b11;

    localparam logic [2:0] NSEL_RN = 3'b001;
    localparam logic [2:0] NSEL_RD = 3'b010;
    localparam logic [2:0] NSEL_RM = 3'b100;

    localparam logic [1:0] WB_C     = 2'b00;
    localparam logic [1:0] WB_IMM   = 2'b01;
    localparam logic [1:0] WB_MDATA = 2'b10;

    localparam logic [1:0] PC_INC    = 2'b00;
    localparam logic [1:0] PC_ZERO   = 2'b01;
    localparam logic [1:0] PC_BRANCH = 2'b10;

    typedef enum logic [3:0] {
        S_RESET, S_FETCH1, S_FETCH2, S_UPDATE, S_DECODE,
        S_A, S_B, S_C, S_D, S_E, S_F, S_G, S_H,
        S_HALT
    } state_t;

endpackage

`default_nettype wire

//--- source/register_file.sv
`default_nettype none

module register_file (
    input  wire               clk,
    input  wire               write,
    input  cpu_pkg::reg_num_t reg_num,
    input  cpu_pkg::word_t    write_data,
    output cpu_pkg::word_t    read_data
);

    cpu_pkg::word_t regs [cpu_pkg::REG_COUNT];

    always_ff @(posedge clk)
    begin
        if (write)
            regs[reg_num] <= write_data;
    end

    // same register number for both ports
    assign read_data = regs[reg_num];

endmodule

`default_nettype wire

//--- source/datapath.sv
`default_nettype none

module datapath (
    input  wire               clk,
    input  cpu_pkg::reg_num_t reg_num,
    input  wire               write,
    input  wire [1:0]         wb_sel,
    input  wire               load_a,
    input  wire               load_b,
    input  wire               load_c,
    input  wire               load_s,
    input  wire               asel,
    input  wire               bsel,
    input  cpu_pkg::shift_t   shift,
    input  cpu_pkg::alu_op_t  alu_op,
    input  cpu_pkg::word_t    mdata,
    input  cpu_pkg::word_t    sximm8,
    input  cpu_pkg::word_t    sximm5,
    output cpu_pkg::word_t    out,
    output logic              n,
    output logic              v,
    output logic              z
);

    cpu_pkg::word_t write_data, read_data;
    cpu_pkg::word_t a_reg, b_reg, c_reg;
    cpu_pkg::word_t b_shifted, ain, bin, alu_out;
    logic           alu_v;

    always_comb
    begin
        case (wb_sel)
            cpu_pkg::WB_IMM:   write_data = sximm8;
            cpu_pkg::WB_MDATA: write_data = mdata;
            default:           write_data = c_reg;
        endcase
    end

    register_file u_rf (
        .clk(clk), .write(write), .reg_num(reg_num),
        .write_data(write_data), .read_data(read_data)
    );

    always_ff @(posedge clk)
    begin
        if (load_a)
            a_reg <= read_data;
        if (load_b)
            b_reg <= read_data;
        if (load_c)
            c_reg <= alu_out;
        if (load_s)
        begin
            z <= (alu_out == '0);
            n <= alu_out[15];
            v <= alu_v;
        end
    end

    always_comb
    begin
        case (shift)
            2'b01:   b_shifted = {b_reg[14:0], 1'b0};
            2'b10:   b_shifted = {1'b0, b_reg[15:1]};
            2'b11:   b_shifted = {b_reg[15], b_reg[15:1]};  // keeps the sign
            default: b_shifted = b_reg;
        endcase
    end

    assign ain = asel ? '0 : a_reg;
    assign bin = bsel ? sximm5 : b_shifted;

    always_comb
    begin
        alu_v = 1'b0;
        case (alu_op)
            cpu_pkg::ALU_ADD: alu_out = ain + bin;
            cpu_pkg::ALU_CMP:
            begin
                alu_out = ain - bin;
                alu_v   = (ain[15] != bin[15]) && (alu_out[15] != ain[15]);
            end
            cpu_pkg::ALU_AND: alu_out = ain & bin;
            default:          alu_out = ~bin;
        endcase
    end

    assign out = c_reg;

endmodule

`default_nettype wire

//--- source/instr_unit.sv
`default_nettype none

module instr_unit (
    input  wire                clk,
    input  wire                load_ir,
    input  cpu_pkg::word_t     read_data,
    input  wire [2:0]          nsel,
    output logic [2:0]         opcode,
    output logic [1:0]         op,
    output logic [2:0]         cond,
    output cpu_pkg::reg_num_t  reg_num,
    output cpu_pkg::shift_t    shift,
    output cpu_pkg::alu_op_t   alu_op,
    output cpu_pkg::word_t     sximm8,
    output cpu_pkg::word_t     sximm5,
    output cpu_pkg::addr_t     branch_offset
);

    cpu_pkg::word_t ir;
    logic           mem_op;

    always_ff @(posedge clk)
    begin
        if (load_ir)
            ir <= read_data;
    end

    assign opcode = ir[15:13];
    assign op     = ir[12:11];
    assign cond   = ir[10:8];   // overlaps Rn

    assign mem_op = (opcode == cpu_pkg::OPC_LDR) || (opcode == cpu_pkg::OPC_STR);
    assign shift  = mem_op ? cpu_pkg::shift_t'(2'b00) : ir[4:3];
    // only the ALU group picks its own operation, everything else adds
    assign alu_op = (opcode == cpu_pkg::OPC_ALU) ? ir[12:11] : cpu_pkg::ALU_ADD;

    assign sximm8        = {{8{ir[7]}}, ir[7:0]};
    assign sximm5        = {{11{ir[4]}}, ir[4:0]};
    assign branch_offset = {ir[7], ir[7:0]};

    always_comb
    begin
        case (nsel)
            cpu_pkg::NSEL_RN: reg_num = ir[10:8];
            cpu_pkg::NSEL_RD: reg_num = ir[7:5];
            cpu_pkg::NSEL_RM: reg_num = ir[2:0];
            default:          reg_num = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- source/control_fsm.sv
`default_nettype none

module control_fsm (
    input  wire               clk,
    input  wire               reset,
    input  wire [2:0]         opcode,
    input  wire [1:0]         op,
    input  wire [2:0]         cond,
    input  wire               n,
    input  wire               v,
    input  wire               z,
    output logic [2:0]        nsel,
    output logic [1:0]        wb_sel,
    output logic              write,
    output logic              load_a,
    output logic              load_b,
    output logic              load_c,
    output logic              load_s,
    output logic              asel,
    output logic              bsel,
    output logic              load_ir,
    output logic              load_pc,
    output logic [1:0]        pc_sel,
    output logic              load_addr,
    output logic              addr_sel,
    output cpu_pkg::mem_cmd_t mem_cmd,
    output logic              halt
);

    cpu_pkg::state_t state, next_state;
    logic            taken;

    always_ff @(posedge clk)
    begin
        if (reset)
            state <= cpu_pkg::S_RESET;
        else
            state <= next_state;
    end

    always_comb
    begin
        case (cond)
            cpu_pkg::COND_AL: taken = 1'b1;
            cpu_pkg::COND_EQ: taken = z;
            cpu_pkg::COND_NE: taken = !z;
            cpu_pkg::COND_LT: taken = (n != v);
            cpu_pkg::COND_LE: taken = (n != v) || z;
            default:          taken = 1'b0;
        endcase
    end

    always_comb
    begin
        next_state = state;
        nsel       = cpu_pkg::NSEL_RN;
        wb_sel     = cpu_pkg::WB_C;
        write      = 1'b0;
        load_a     = 1'b0;
        load_b     = 1'b0;
        load_c     = 1'b0;
        load_s     = 1'b0;
        asel       = 1'b0;
        bsel       = 1'b0;
        load_ir    = 1'b0;
        load_pc    = 1'b0;
        pc_sel     = cpu_pkg::PC_INC;
        load_addr  = 1'b0;
        addr_sel   = 1'b0;
        mem_cmd    = cpu_pkg::MEM_NONE;
        halt       = 1'b0;

        case (state)
            cpu_pkg::S_RESET:
            begin
                load_pc    = 1'b1;
                pc_sel     = cpu_pkg::PC_ZERO;
                next_state = cpu_pkg::S_FETCH1;
            end
            cpu_pkg::S_FETCH1:
            begin
                addr_sel   = 1'b1;
                mem_cmd    = cpu_pkg::MEM_READ;
                next_state = cpu_pkg::S_FETCH2;
            end
            cpu_pkg::S_FETCH2:
            begin
                addr_sel   = 1'b1;
                mem_cmd    = cpu_pkg::MEM_READ;
                load_ir    = 1'b1;
                next_state = cpu_pkg::S_UPDATE;
            end
            cpu_pkg::S_UPDATE:
            begin
                load_pc    = 1'b1;
                next_state = cpu_pkg::S_DECODE;
            end
            cpu_pkg::S_DECODE:
            begin
                case (opcode)
                    cpu_pkg::OPC_BRANCH,
                    cpu_pkg::OPC_ALU,
                    cpu_pkg::OPC_LDR,
                    cpu_pkg::OPC_STR:  next_state = cpu_pkg::S_A;
                    cpu_pkg::OPC_MOV:
                        if (op == cpu_pkg::OP_MOV_IMM || op == cpu_pkg::OP_MOV_REG)
                            next_state = cpu_pkg::S_A;
                        else
                            next_state = cpu_pkg::S_FETCH1;
                    cpu_pkg::OPC_HALT: next_state = cpu_pkg::S_HALT;
                    default:           next_state = cpu_pkg::S_FETCH1;
                endcase
            end
            cpu_pkg::S_A:
            begin
                case (opcode)
                    cpu_pkg::OPC_MOV:
                        if (op == cpu_pkg::OP_MOV_IMM)
                        begin
                            wb_sel     = cpu_pkg::WB_IMM;  // Rn <= sximm8
                            write      = 1'b1;
                            next_state = cpu_pkg::S_FETCH1;
                        end
                        else
                        begin
                            nsel       = cpu_pkg::NSEL_RM;
                            load_b     = 1'b1;
                            next_state = cpu_pkg::S_B;
                        end
                    cpu_pkg::OPC_BRANCH:
                    begin
                        load_pc    = taken;
                        pc_sel     = taken ? cpu_pkg::PC_BRANCH : cpu_pkg::PC_INC;
                        next_state = cpu_pkg::S_FETCH1;
                    end
                    default:
                    begin
                        load_a     = 1'b1;  // Rn into A
                        next_state = (opcode == cpu_pkg::OPC_ALU) ? cpu_pkg::S_B : cpu_pkg::S_C;
                    end
                endcase
            end
            cpu_pkg::S_B:
            begin
                if (opcode == cpu_pkg::OPC_MOV)
                begin
                    asel   = 1'b1;
                    load_c = 1'b1;
                end
                else
                begin
                    nsel   = cpu_pkg::NSEL_RM;
                    load_b = 1'b1;
                end
                next_state = cpu_pkg::S_C;
            end
            cpu_pkg::S_C:
            begin
                if (opcode == cpu_pkg::OPC_MOV)
                begin
                    nsel       = cpu_pkg::NSEL_RD;
                    write      = 1'b1;
                    next_state = cpu_pkg::S_FETCH1;
                end
                else
                begin
                    bsel       = (opcode != cpu_pkg::OPC_ALU);  // Rn + sximm5 for LDR/STR
                    load_s     = (opcode == cpu_pkg::OPC_ALU) && (op == cpu_pkg::ALU_CMP);
                    load_c     = !load_s;
                    next_state = cpu_pkg::S_D;
                end
            end
            cpu_pkg::S_D:
            begin
                if (opcode == cpu_pkg::OPC_ALU)
                begin
                    nsel       = cpu_pkg::NSEL_RD;
                    write      = (op != cpu_pkg::ALU_CMP);
                    next_state = cpu_pkg::S_FETCH1;
                end
                else
                begin
                    load_addr  = 1'b1;
                    next_state = cpu_pkg::S_E;
                end
            end
            cpu_pkg::S_E:
            begin
                if (opcode == cpu_pkg::OPC_LDR)
                    mem_cmd = cpu_pkg::MEM_READ;
                next_state = cpu_pkg::S_F;
            end
            cpu_pkg::S_F:
            begin
                nsel = cpu_pkg::NSEL_RD;
                if (opcode == cpu_pkg::OPC_LDR)
                begin
                    mem_cmd    = cpu_pkg::MEM_READ;  // hold the read while Rd is written
                    wb_sel     = cpu_pkg::WB_MDATA;
                    write      = 1'b1;
                    next_state = cpu_pkg::S_FETCH1;
                end
                else
                begin
                    load_b     = 1'b1;
                    next_state = cpu_pkg::S_G;
                end
            end
            cpu_pkg::S_G:
            begin
                asel       = 1'b1;  // C <= Rd, the store data
                load_c     = 1'b1;
                next_state = cpu_pkg::S_H;
            end
            cpu_pkg::S_H:
            begin
                mem_cmd    = cpu_pkg::MEM_WRITE;
                next_state = cpu_pkg::S_FETCH1;
            end
            cpu_pkg::S_HALT:
            begin
                halt = 1'b1;  // parked until reset
            end
            default: next_state = cpu_pkg::S_RESET;
        endcase
    end

endmodule

`default_nettype wire

//--- source/address_unit.sv
`default_nettype none

module address_unit (
    input  wire            clk,
    input  wire            load_pc,
    input  wire [1:0]      pc_sel,
    input  cpu_pkg::addr_t branch_offset,
    input  wire            load_addr,
    input  wire            addr_sel,
    input  cpu_pkg::word_t data_addr_in,
    output cpu_pkg::addr_t mem_addr
);

    cpu_pkg::addr_t pc, next_pc, data_addr;

    // pc already points past the branch when the target is formed
    always_comb
    begin
        case (pc_sel)
            cpu_pkg::PC_ZERO:   next_pc = '0;
            cpu_pkg::PC_BRANCH: next_pc = pc + branch_offset;
            default:            next_pc = pc + 1'b1;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (load_pc)
            pc <= next_pc;
        if (load_addr)
            data_addr <= data_addr_in[cpu_pkg::ADDR_W-1:0];
    end

    assign mem_addr = addr_sel ? pc : data_addr;  // pc during fetch

endmodule

`default_nettype wire

//--- source/cpu_top.sv
`default_nettype none

module cpu_top (
    input  wire               clk,
    input  wire               reset,
    input  cpu_pkg::word_t    read_data,
    output cpu_pkg::mem_cmd_t mem_cmd,
    output cpu_pkg::addr_t    mem_addr,
    output cpu_pkg::word_t    out,
    output logic              n,
    output logic              v,
    output logic              z,
    output logic              halt
);

    logic [2:0]        opcode;
    logic [1:0]        op;
    logic [2:0]        cond;
    cpu_pkg::reg_num_t reg_num;
    cpu_pkg::shift_t   shift;
    cpu_pkg::alu_op_t  alu_op;
    cpu_pkg::word_t    sximm8;
    cpu_pkg::word_t    sximm5;
    cpu_pkg::addr_t    branch_offset;

    logic [2:0] nsel;
    logic [1:0] wb_sel;
    logic [1:0] pc_sel;
    logic       write, load_a, load_b, load_c, load_s;
    logic       asel, bsel;
    logic       load_ir, load_pc, load_addr, addr_sel;

    instr_unit u_instr (
        .clk(clk), .load_ir(load_ir), .read_data(read_data), .nsel(nsel),
        .opcode(opcode), .op(op), .cond(cond), .reg_num(reg_num), .shift(shift),
        .alu_op(alu_op), .sximm8(sximm8), .sximm5(sximm5),
        .branch_offset(branch_offset)
    );

    control_fsm u_ctrl (
        .clk(clk), .reset(reset), .opcode(opcode), .op(op), .cond(cond),
        .n(n), .v(v), .z(z),
        .nsel(nsel), .wb_sel(wb_sel), .write(write),
        .load_a(load_a), .load_b(load_b), .load_c(load_c), .load_s(load_s),
        .asel(asel), .bsel(bsel), .load_ir(load_ir), .load_pc(load_pc),
        .pc_sel(pc_sel), .load_addr(load_addr), .addr_sel(addr_sel),
        .mem_cmd(mem_cmd), .halt(halt)
    );

    // memory read data doubles as mdata for LDR
    datapath u_dp (
        .clk(clk), .reg_num(reg_num), .write(write), .wb_sel(wb_sel),
        .load_a(load_a), .load_b(load_b), .load_c(load_c), .load_s(load_s),
        .asel(asel), .bsel(bsel), .shift(shift), .alu_op(alu_op),
        .mdata(read_data), .sximm8(sximm8), .sximm5(sximm5),
        .out(out), .n(n), .v(v), .z(z)
    );

    address_unit u_addr (
        .clk(clk), .load_pc(load_pc), .pc_sel(pc_sel),
        .branch_offset(branch_offset), .load_addr(load_addr),
        .addr_sel(addr_sel), .data_addr_in(out), .mem_addr(mem_addr)
    );

endmodule

`default_nettype wire

//--- tb/cpu_properties.sv
`default_nettype none

module cpu_properties (
    input wire               clk,
    input wire               reset,
    input cpu_pkg::mem_cmd_t mem_cmd,
    input cpu_pkg::addr_t    mem_addr,
    input wire               halt
);
    timeunit 1ns;
    timeprecision 100ps;

    // 2'b10 is not a defined memory command
    cmd_legal: assert property (@(posedge clk) disable iff (reset) mem_cmd != 2'b10)
        else $error("mem_cmd shows the undefined code 2'b10");

    halt_quiet: assert property (@(posedge clk) disable iff (reset)
        halt |-> mem_cmd == cpu_pkg::MEM_NONE)
        else $error("memory access while halted");

    halt_sticky: assert property (@(posedge clk) disable iff (reset) halt |=> halt)
        else $error("halt dropped without a reset");

    // generated programs keep their stores at 256 and above
    store_region: assert property (@(posedge clk) disable iff (reset)
        mem_cmd == cpu_pkg::MEM_WRITE |-> mem_addr[8])
        else $error("store below the data region at address %0d", mem_addr);

endmodule

bind cpu_top cpu_properties props0 (
    .clk(clk), .reset(reset), .mem_cmd(mem_cmd), .mem_addr(mem_addr), .halt(halt)
);

`default_nettype wire

//--- tb/cpu_tb.sv
`default_nettype none

module cpu_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int PROGRAMS     = 20;
    localparam int RANDOM_LEN   = 30;
    localparam int DUMP_BASE    = 8 + RANDOM_LEN;   // first of the eight dump stores
    localparam int MEM_WORDS    = 512;
    localparam int RESET_CYCLES = 5;
    localparam int CYCLE_LIMIT  = PROGRAMS * 40 * 14 + PROGRAMS * (RESET_CYCLES + 2);

    logic              clk;
    logic              reset;
    cpu_pkg::word_t    read_data;
    cpu_pkg::mem_cmd_t mem_cmd;
    cpu_pkg::addr_t    mem_addr;
    cpu_pkg::word_t    out;
    logic              n, v, z;
    logic              halt;

    cpu_pkg::word_t mem [MEM_WORDS];
    cpu_pkg::word_t image [MEM_WORDS];       // next program, copied into mem during reset
    cpu_pkg::word_t model_mem [MEM_WORDS];
    cpu_pkg::word_t model_regs [cpu_pkg::REG_COUNT];
    logic           model_n, model_v, model_z;
    logic           load_image;
    cpu_pkg::addr_t exp_addr [$];
    cpu_pkg::word_t exp_data [$];
    int             prog_idx;
    int             cycles = 0;

    cpu_top dut0 (
        .clk(clk), .reset(reset), .read_data(read_data), .mem_cmd(mem_cmd),
        .mem_addr(mem_addr), .out(out), .n(n), .v(v), .z(z), .halt(halt)
    );

    always #2 clk = ~clk;

    assign read_data = mem[mem_addr];  // same-cycle answer

    always @(posedge clk)
    begin
        if (load_image)
        begin
            for (int i = 0; i < MEM_WORDS; i++)
                mem[i] <= image[i];
        end
        else if (mem_cmd == cpu_pkg::MEM_WRITE)
            mem[mem_addr] <= out;
    end

    always @(posedge clk)
    begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT)
        begin
            $display("Timeout: program %0d did not halt within %0d cycles",
                     prog_idx, CYCLE_LIMIT);
            report_failure();
        end
    end

    task automatic report_failure();
        $display("Test FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    function automatic cpu_pkg::word_t instr_word(logic [2:0] opc, logic [1:0] op,
                                                  logic [2:0] hi, logic [7:0] lo);
        return {opc, op, hi, lo};
    endfunction

    function automatic cpu_pkg::word_t shifted(cpu_pkg::word_t b, logic [1:0] sh);
        case (sh)
            2'b01:   return b << 1;
            2'b10:   return b >> 1;
            2'b11:   return cpu_pkg::word_t'($signed(b) >>> 1);
            default: return b;
        endcase
    endfunction

    function automatic cpu_pkg::word_t random_instr(int slot);
        logic [2:0] rn, rd, rd_w, rm, cond;
        logic [1:0] sh;
        logic [7:0] imm8;
        logic [4:0] imm5;
        int         max_off;
        int         kind;
        rn   = 3'($urandom % 8);
        rd   = 3'($urandom % 8);
        rd_w = 3'($urandom % 7);  // R7 stays the data base
        rm   = 3'($urandom % 8);
        sh   = 2'($urandom % 4);
        imm8 = 8'($urandom);
        imm5 = 5'($urandom);
        cond = 3'($urandom % 5);
        max_off = 29 - slot;      // never jump past the dump
        if (max_off > 6)
            max_off = 6;
        // a CMP first, so the flags are known before any branch
        kind = (slot == 0) ? 3 : int'($urandom % 10);
        case (kind)
            0: return instr_word(cpu_pkg::OPC_MOV, cpu_pkg::OP_MOV_IMM, rd_w, imm8);
            1: return instr_word(cpu_pkg::OPC_MOV, cpu_pkg::OP_MOV_REG, rn, {rd_w, sh, rm});
            2: return instr_word(cpu_pkg::OPC_ALU, cpu_pkg::ALU_ADD, rn, {rd_w, sh, rm});
            3: return instr_word(cpu_pkg::OPC_ALU, cpu_pkg::ALU_CMP, rn, {rd, sh, rm});
            4: return instr_word(cpu_pkg::OPC_ALU, cpu_pkg::ALU_AND, rn, {rd_w, sh, rm});
            5: return instr_word(cpu_pkg::OPC_ALU, cpu_pkg::ALU_MVN, rn, {rd_w, sh, rm});
            6: return instr_word(cpu_pkg::OPC_LDR, 2'b00, 3'd7, {rd_w, imm5});
            7: return instr_word(cpu_pkg::OPC_STR, 2'b00, 3'd7, {rd, imm5});
            default: return instr_word(cpu_pkg::OPC_BRANCH, 2'b00, cond,
                                       8'($urandom % (max_off + 1)));
        endcase
    endfunction

    task automatic build_program(int p);
        for (int a = 0; a < MEM_WORDS; a++)
            image[a] = 16'(a * 16'h9e37) ^ {7'(p), 9'(a)};
        for (int r = 0; r < 7; r++)
            image[r] = instr_word(cpu_pkg::OPC_MOV, cpu_pkg::OP_MOV_IMM, 3'(r), 8'($urandom));
        // -128 puts the data base at address 384
        image[7] = instr_word(cpu_pkg::OPC_MOV, cpu_pkg::OP_MOV_IMM, 3'd7, 8'h80);
        for (int s = 0; s < RANDOM_LEN; s++)
            image[8 + s] = random_instr(s);
        for (int r = 0; r < 8; r++)
            image[DUMP_BASE + r] = instr_word(cpu_pkg::OPC_STR, 2'b00, 3'd7, {3'(r), 5'(r)});
        image[DUMP_BASE + 8] = instr_word(cpu_pkg::OPC_HALT, 2'b00, 3'd0, 8'd0);
    endtask

    task automatic run_model();
        cpu_pkg::word_t ir, a, b, res;
        cpu_pkg::addr_t pc, addr;
        logic [2:0]     opc, rn, rd, rm;
        logic [1:0]     op, sh;
        logic           taken;
        int             diff;
        pc = '0;
        exp_addr.delete();
        exp_data.delete();
        for (int i = 0; i < MEM_WORDS; i++)
            model_mem[i] = image[i];
        for (int step = 0; step < 200; step++)
        begin
            ir  = model_mem[pc];
            pc  = pc + 9'd1;
            opc = ir[15:13];
            op  = ir[12:11];
            rn  = ir[10:8];
            rd  = ir[7:5];
            sh  = ir[4:3];
            rm  = ir[2:0];
            if (opc == cpu_pkg::OPC_HALT)
                break;
            addr = 9'(model_regs[rn] + {{11{ir[4]}}, ir[4:0]});
            a    = model_regs[rn];
            b    = shifted(model_regs[rm], sh);
            case (opc)
                cpu_pkg::OPC_MOV:
                    if (op == cpu_pkg::OP_MOV_IMM)
                        model_regs[rn] = {{8{ir[7]}}, ir[7:0]};
                    else
                        model_regs[rd] = b;
                cpu_pkg::OPC_ALU:
                    case (op)
                        cpu_pkg::ALU_ADD: model_regs[rd] = a + b;
                        cpu_pkg::ALU_CMP:
                        begin
                            res     = a - b;
                            diff    = int'($signed(a)) - int'($signed(b));
                            model_z = (res == 16'd0);
                            model_n = res[15];
                            model_v = (diff > 32767) || (diff < -32768);
                        end
                        cpu_pkg::ALU_AND: model_regs[rd] = a & b;
                        default:          model_regs[rd] = ~b;
                    endcase
                cpu_pkg::OPC_LDR: model_regs[rd] = model_mem[addr];
                cpu_pkg::OPC_STR:
                begin
                    model_mem[addr] = model_regs[rd];
                    exp_addr.push_back(addr);
                    exp_data.push_back(model_regs[rd]);
                end
                default:
                begin
                    case (rn)
                        cpu_pkg::COND_AL: taken = 1'b1;
                        cpu_pkg::COND_EQ: taken = model_z;
                        cpu_pkg::COND_NE: taken = !model_z;
                        cpu_pkg::COND_LT: taken = (model_n != model_v);
                        default:          taken = (model_n != model_v) || model_z;
                    endcase
                    if (taken)
                        pc = pc + {ir[7], ir[7:0]};
                end
            endcase
        end
    endtask

    task automatic check_write();
        cpu_pkg::addr_t want_addr;
        cpu_pkg::word_t want_data;
        assert (exp_addr.size() != 0) else
        begin
            $display("Program %0d made a memory write that the model does not make", prog_idx);
            report_failure();
        end
        want_addr = exp_addr.pop_front();
        want_data = exp_data.pop_front();
        assert (mem_addr === want_addr && out === want_data) else
        begin
            $display("[ERROR] %0t: program %0d wrote %h to %0d, expected %h to %0d",
                     $time, prog_idx, out, mem_addr, want_data, want_addr);
            report_failure();
        end
    endtask

    task automatic run_program();
        logic first_read;
        first_read = 1'b1;
        @(negedge clk);
        reset      = 1'b1;
        load_image = 1'b1;
        @(negedge clk);
        load_image = 1'b0;
        repeat (RESET_CYCLES - 1) @(negedge clk);
        reset = 1'b0;
        assert (halt === 1'b0) else
        begin
            $display("[ERROR] %0t: halt is %b right after reset", $time, halt);
            report_failure();
        end
        while (halt !== 1'b1)
        begin
            if (first_read && mem_cmd == cpu_pkg::MEM_READ)
            begin
                assert (mem_addr === 9'd0) else
                begin
                    $display("[ERROR] %0t: first read at %0d, expected 0", $time, mem_addr);
                    report_failure();
                end
                first_read = 1'b0;
            end
            if (mem_cmd == cpu_pkg::MEM_WRITE)
                check_write();
            @(negedge clk);
        end
        assert (exp_addr.size() == 0) else
        begin
            $display("[ERROR] %0t: program %0d halted with %0d expected writes missing",
                     $time, prog_idx, exp_addr.size());
            report_failure();
        end
        assert ({n, v, z} === {model_n, model_v, model_z}) else
        begin
            $display("[ERROR] %0t: program %0d flags nvz %b%b%b, expected %b%b%b",
                     $time, prog_idx, n, v, z, model_n, model_v, model_z);
            report_failure();
        end
    endtask

    initial
    begin
        void'($urandom(32'h9d2fae7a));
        clk        = 1'b0;
        reset      = 1'b1;
        load_image = 1'b0;
        model_n    = 1'b0;
        model_v    = 1'b0;
        model_z    = 1'b0;
        for (prog_idx = 0; prog_idx < PROGRAMS; prog_idx++)
        begin
            build_program(prog_idx);
            run_model();
            run_program();
        end
        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire

//--- filelist.f
source/cpu_pkg.sv
source/register_file.sv
source/datapath.sv
source/instr_unit.sv
source/control_fsm.sv
source/address_unit.sv
source/cpu_top.sv
tb/cpu_properties.sv
tb/cpu_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/100ps
TOP       = cpu_tb
FILELIST  = filelist.f
OBJDIR    = obj_dir
SIM       = $(OBJDIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

# the run passes only if the simulation printed the pass line
run: compile
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "Test OK"

clean:
	rm -rf $(OBJDIR)
